/* list.f */
+incdir+include
verilog/obj_pkg.sv
verilog/video_pkg.sv
verilog/obj_ram.sv
verilog/obj_scan.sv
verilog/obj_draw.sv
verilog/obj_line_buf.sv
verilog/obj_top.sv
tb/tb_obj_top.sv

/* Bender.yml */
package:
  name: obj_engine

sources:
  - include_dirs:
      - include
    files:
      - verilog/obj_pkg.sv
      - verilog/video_pkg.sv
      - verilog/obj_ram.sv
      - verilog/obj_scan.sv
      - verilog/obj_draw.sv
      - verilog/obj_line_buf.sv
      - verilog/obj_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_obj_top.sv

/* tb/tb_obj_top.sv */
// Directed testbench for the object engine top level, with a graphics ROM model and video timing
`timescale 1ns/1ps
`include "obj_defines.svh"

module tb_obj_top;

    // One line is 320 pixel slots of two cycles, plus two cycles to flush the capture
    localparam int LINE_CYCLES = 642;
    // Lines run by the five display tests, warm-up lines included
    localparam int TOTAL_LINES = 32;
    // CPU traffic, table loads and reset fit well inside the margin
    localparam int MAX_CYCLES  = TOTAL_LINES * LINE_CYCLES + 2000;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic [6:0]             cpu_addr;
    logic [7:0]             cpu_dout;
    logic                   obj_cs;
    logic                   cpu_rnw;
    logic [7:0]             obj_dout;
    logic                   hinit;
    logic                   pxl_cen;
    logic [7:0]             vrender;
    logic [8:0]             hdump;
    logic [`OBJ_ROM_AW-1:0] rom_addr;
    logic                   rom_cs;
    logic [31:0]            rom_data;
    logic                   rom_ok;
    video_pkg::pixel_t      pxl;

    // Shadow of the attribute table, byte k of entry n at 4n+k
    logic [7:0]  tbl [128];
    // Expected line buffer contents and the captured display line
    logic [7:0]  exp_buf [256];
    logic [7:0]  line_cap [320];
    // Capture pipeline, what the DUT saw at the last edge
    logic        cen_q = 1'b0;
    logic [8:0]  hdump_q = '0;
    // ROM answer delays, drawn once after seeding
    logic [1:0]  rom_delay [64];
    logic [5:0]  req_cnt = '0;
    logic        rom_slow = 1'b0;
    // Address seen when the strobe first showed up
    logic [`OBJ_ROM_AW-1:0] req_addr;
    int          wait_cycles;
    int          cycles = 0;

    obj_top i_dut (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cpu_addr ( cpu_addr ),
        .cpu_dout ( cpu_dout ),
        .obj_cs   ( obj_cs   ),
        .cpu_rnw  ( cpu_rnw  ),
        .obj_dout ( obj_dout ),
        .hinit    ( hinit    ),
        .pxl_cen  ( pxl_cen  ),
        .vrender  ( vrender  ),
        .hdump    ( hdump    ),
        .rom_addr ( rom_addr ),
        .rom_cs   ( rom_cs   ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   ),
        .pxl      ( pxl      )
    );

    // 100 ns period
    always #50 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $fatal(1, "Simulation timed out");
        end
    end

    // ROM content, nibble i is the address plus i
    function automatic logic [31:0] rom_word(input logic [`OBJ_ROM_AW-1:0] addr);
        logic [31:0] w;
        for (int i = 0; i < 8; i++) begin
            w[4*i +: 4] = addr[3:0] + 4'(i);
        end
        return w;
    endfunction

    // ROM model, answers a held strobe after 1 to 3 cycles
    always begin
        @(posedge clk);
        if (rom_cs) begin
            wait_cycles = rom_slow ? 3 : int'(rom_delay[req_cnt]);
            req_cnt = req_cnt + 6'd1;
            req_addr = rom_addr;
            repeat (wait_cycles - 1) @(posedge clk);
            rom_data <= rom_word(rom_addr);
            rom_ok   <= 1'b1;
            @(posedge clk);
            // Strobe and address held through the rom_ok cycle
            check_value("rom_cs", rom_cs, 1'b1);
            check_value("rom_addr", rom_addr, req_addr);
            rom_ok <= 1'b0;
        end
    end

    // pxl loaded at one edge is stable and sampled at the next
    always @(posedge clk) begin
        if (cen_q) begin
            line_cap[hdump_q] = pxl;
        end
        cen_q   <= pxl_cen;
        hdump_q <= hdump;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, want);
            $display("TESTBENCH FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic write_byte(input logic [6:0] addr, input logic [7:0] data);
        @(posedge clk);
        cpu_addr <= addr;
        cpu_dout <= data;
        obj_cs   <= 1'b1;
        cpu_rnw  <= 1'b0;
        @(posedge clk);
        obj_cs   <= 1'b0;
        cpu_rnw  <= 1'b1;
        tbl[addr] = data;
    endtask

    // Read data is registered, valid after the sampling edge
    task automatic read_check(input logic [6:0] addr);
        @(posedge clk);
        cpu_addr <= addr;
        obj_cs   <= 1'b1;
        cpu_rnw  <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_value($sformatf("obj_dout at 0x%0h", addr), obj_dout, tbl[addr]);
    endtask

    task automatic set_object(input int n, input logic [7:0] y, input logic [7:0] code,
                              input logic [7:0] attr, input logic [7:0] x);
        write_byte(7'(4*n), y);
        write_byte(7'(4*n + 1), code);
        write_byte(7'(4*n + 2), attr);
        write_byte(7'(4*n + 3), x);
    endtask

    // Lines 200..207, never displayed here
    task automatic hide_all();
        for (int n = 0; n < `OBJ_COUNT; n++) begin
            write_byte(7'(4*n), 8'd200);
        end
    endtask

    // Pixel slot: hinit cycle without pxl_cen, then the pxl_cen cycle
    task automatic run_line(input logic [7:0] line);
        for (int h = 0; h < 320; h++) begin
            @(posedge clk);
            hinit   <= (h == 0);
            pxl_cen <= 1'b0;
            hdump   <= 9'(h);
            if (h == 0) begin
                vrender <= line;
            end
            @(posedge clk);
            hinit   <= 1'b0;
            pxl_cen <= 1'b1;
        end
        @(posedge clk);
        pxl_cen <= 1'b0;
        @(posedge clk);
        @(negedge clk);
    endtask

    // Reference line from the table shadow, later entries on top
    task automatic build_line(input logic [7:0] line);
        logic [7:0]             y;
        logic [7:0]             code;
        logic [7:0]             attr;
        logic [7:0]             x;
        logic [7:0]             row;
        logic [7:0]             pos;
        logic [`OBJ_ROM_AW-1:0] addr;
        logic [31:0]            word;
        logic [3:0]             nib;
        for (int p = 0; p < 256; p++) begin
            exp_buf[p] = 8'h00;
        end
        for (int n = 0; n < `OBJ_COUNT; n++) begin
            y    = tbl[4*n];
            code = tbl[4*n + 1];
            attr = tbl[4*n + 2];
            x    = tbl[4*n + 3];
            row  = line - y;
            if (row < 8'd8) begin
                addr = code;
                addr = addr * 8 + row;
                word = rom_word(addr);
                for (int i = 0; i < 8; i++) begin
                    nib = word[4*i +: 4];
                    pos = attr[4] ? x + 8'(7 - i) : x + 8'(i);
                    // Index 0 lets the lower object through
                    if (nib != 4'd0) begin
                        exp_buf[pos] = {attr[3:0], nib};
                    end
                end
            end
        end
    endtask

    // Only the first 256 slots read a location before its erase
    task automatic check_line(input logic [7:0] line);
        logic [7:0] want;
        build_line(line);
        for (int h = 0; h < 320; h++) begin
            want = (h < 256) ? exp_buf[8'(h - `OBJ_HOFFSET)] : 8'h00;
            check_value($sformatf("pxl at hdump %0d line %0d", h, line), line_cap[h], want);
        end
    endtask

    // Warm-up line flushes the other half, then each line is checked
    task automatic show_lines(input logic [7:0] first, input logic [7:0] last);
        run_line(first - 8'd1);
        for (int l = first; l <= last; l++) begin
            run_line(8'(l));
            check_line(8'(l));
        end
    endtask

    task automatic cpu_readback();
        for (int a = 0; a < 128; a++) begin
            write_byte(7'(a), 8'($urandom));
        end
        for (int a = 0; a < 128; a++) begin
            read_check(7'(a));
        end
        hide_all();
    endtask

    task automatic single_object(input logic [7:0] attr);
        set_object(5, 8'd40, 8'h12, attr, 8'd100);
        show_lines(8'd39, 8'd48);
        hide_all();
    endtask

    // Higher entry has holes at x+7 and x+6 on rows 1 and 2
    task automatic overlap_priority();
        set_object(3, 8'd60, 8'h20, 8'h05, 8'd55);
        set_object(9, 8'd60, 8'h21, 8'h0a, 8'd53);
        show_lines(8'd61, 8'd62);
        hide_all();
    endtask

    // Last row wraps to 0..3, the two lines after must be empty
    task automatic wrap_and_erase();
        set_object(0, 8'd80, 8'h30, 8'h07, 8'd252);
        show_lines(8'd87, 8'd89);
        hide_all();
    endtask

    task automatic rom_stall();
        set_object(2, 8'd100, 8'h41, 8'h01, 8'd10);
        set_object(7, 8'd101, 8'h52, 8'h12, 8'd70);
        set_object(15, 8'd99, 8'h63, 8'h03, 8'd130);
        set_object(31, 8'd100, 8'h74, 8'h1c, 8'd190);
        rom_slow = 1'b1;
        show_lines(8'd103, 8'd104);
        rom_slow = 1'b0;
        hide_all();
    endtask

    initial begin
        void'($urandom(30494));
        for (int i = 0; i < 64; i++) begin
            rom_delay[i] = 2'(1 + $urandom % 3);
        end
        rst_n    <= 1'b0;
        cpu_addr <= '0;
        cpu_dout <= '0;
        obj_cs   <= 1'b0;
        cpu_rnw  <= 1'b1;
        hinit    <= 1'b0;
        pxl_cen  <= 1'b0;
        vrender  <= '0;
        hdump    <= '0;
        rom_data <= '0;
        rom_ok   <= 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        // Outputs idle out of reset
        check_value("rom_cs", rom_cs, 1'b0);
        check_value("pxl", pxl, 8'h00);
        cpu_readback();
        single_object(8'h03);
        // Same object mirrored
        single_object(8'h13);
        overlap_priority();
        wrap_and_erase();
        rom_stall();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* verilog/obj_top.sv */
// Object engine top level, ties the table, scanner, drawer and line buffer to CPU, video and ROM
`timescale 1ns/1ps
`include "obj_defines.svh"

module obj_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // CPU
    input  logic [6:0]             cpu_addr,
    input  logic [7:0]             cpu_dout,
    input  logic                   obj_cs,
    input  logic                   cpu_rnw,
    output logic [7:0]             obj_dout,
    // Video timing
    input  logic                   hinit,
    input  logic                   pxl_cen,
    input  logic [7:0]             vrender,
    input  logic [8:0]             hdump,
    // Graphics ROM
    output logic [`OBJ_ROM_AW-1:0] rom_addr,
    output logic                   rom_cs,
    input  logic [31:0]            rom_data,
    input  logic                   rom_ok,
    // Object pixel out
    output video_pkg::pixel_t      pxl
);

    // Table to scanner
    logic [5:0]            scan_addr;
    logic [7:0]            even_q;
    logic [7:0]            odd_q;
    // Scanner to drawer
    logic                  draw_start;
    logic                  draw_busy;
    logic [31:0]           draw_data;
    logic [7:0]            draw_x;
    logic [7:0]            draw_attr;
    // Drawer to line buffer
    logic                  wr_en;
    video_pkg::lbuf_addr_t wr_addr;
    video_pkg::pixel_t     wr_pixel;

    obj_ram u_ram (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .cpu_addr   ( cpu_addr   ),
        .cpu_dout   ( cpu_dout   ),
        .obj_cs     ( obj_cs     ),
        .cpu_rnw    ( cpu_rnw    ),
        .obj_dout   ( obj_dout   ),
        .scan_addr  ( scan_addr  ),
        .even_q     ( even_q     ),
        .odd_q      ( odd_q      )
    );

    obj_scan u_scan (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .hinit      ( hinit      ),
        .vrender    ( vrender    ),
        .even_q     ( even_q     ),
        .odd_q      ( odd_q      ),
        .scan_addr  ( scan_addr  ),
        .rom_addr   ( rom_addr   ),
        .rom_cs     ( rom_cs     ),
        .rom_data   ( rom_data   ),
        .rom_ok     ( rom_ok     ),
        .draw_busy  ( draw_busy  ),
        .draw_start ( draw_start ),
        .draw_data  ( draw_data  ),
        .draw_x     ( draw_x     ),
        .draw_attr  ( draw_attr  )
    );

    obj_draw u_draw (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .draw_start ( draw_start ),
        .draw_data  ( draw_data  ),
        .draw_x     ( draw_x     ),
        .draw_attr  ( draw_attr  ),
        .draw_busy  ( draw_busy  ),
        .wr_en      ( wr_en      ),
        .wr_addr    ( wr_addr    ),
        .wr_pixel   ( wr_pixel   )
    );

    obj_line_buf u_lbuf (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .hinit      ( hinit      ),
        .pxl_cen    ( pxl_cen    ),
        .hdump      ( hdump      ),
        .wr_en      ( wr_en      ),
        .wr_addr    ( wr_addr    ),
        .wr_pixel   ( wr_pixel   ),
        .pxl        ( pxl        )
    );

endmodule

/* verilog/obj_line_buf.sv */
// Ping-pong object line buffer, one half filled by the drawer while the other is shown and erased
`timescale 1ns/1ps
`include "obj_defines.svh"

module obj_line_buf (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  hinit,
    input  logic                  pxl_cen,
    input  logic [8:0]            hdump,
    // Drawer side
    input  logic                  wr_en,
    input  video_pkg::lbuf_addr_t wr_addr,
    input  video_pkg::pixel_t     wr_pixel,
    // Display side
    output video_pkg::pixel_t     pxl
);

    // Pixel storage, no reset
    video_pkg::pixel_t mem [2][256];

    // One flag per location and half
    // A cleared flag reads as an empty pixel
    logic [1:0][255:0]     valid;

    logic                  bank;
    logic                  wr_bank;
    logic                  rd_bank;
    video_pkg::lbuf_addr_t rd_addr;

    // Drawer fills one half, the display reads the other
    assign wr_bank = bank;
    assign rd_bank = ~bank;

    // Display lags hdump by a fixed offset
    assign rd_addr = hdump[7:0] - 8'(`OBJ_HOFFSET);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_bank][wr_addr] <= wr_pixel;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank  <= 1'b0;
            valid <= '0;
            pxl   <= '0;
        end else begin
            // Swap halves at the start of each line
            if (hinit) begin
                bank <= ~bank;
            end
            if (wr_en) begin
                valid[wr_bank][wr_addr] <= 1'b1;
            end
            if (pxl_cen) begin
                pxl <= valid[rd_bank][rd_addr] ? mem[rd_bank][rd_addr] : '0;
                // Erase behind the read, ready for the next fill
                valid[rd_bank][rd_addr] <= 1'b0;
            end
        end
    end

endmodule

/* verilog/obj_draw.sv */
// Object drawer, turns one fetched ROM row into eight line buffer writes with flip and transparency
`timescale 1ns/1ps

module obj_draw (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   draw_start,
    input  logic [31:0]            draw_data,
    input  logic [7:0]             draw_x,
    input  logic [7:0]             draw_attr,
    output logic                   draw_busy,
    output logic                   wr_en,
    output video_pkg::lbuf_addr_t  wr_addr,
    output video_pkg::pixel_t      wr_pixel
);

    logic                  busy;
    logic [2:0]            cnt;
    logic [31:0]           row_q;
    video_pkg::lbuf_addr_t x_q;
    logic [3:0]            color_q;
    logic                  flip_q;
    logic [3:0]            nib;
    logic [2:0]            offset;

    // Eight busy cycles, one pixel each
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (busy) begin
            cnt <= cnt + 3'd1;
            if (cnt == 3'd7) begin
                busy <= 1'b0;
            end
        end else if (draw_start) begin
            busy <= 1'b1;
            cnt  <= '0;
        end
    end

    // Row latch, shifted so the current pixel is always in the low nibble
    always_ff @(posedge clk) begin
        if (!busy && draw_start) begin
            row_q   <= draw_data;
            x_q     <= draw_x;
            color_q <= draw_attr[3:0];
            flip_q  <= draw_attr[obj_pkg::ATTR_FLIP];
        end else if (busy) begin
            row_q <= row_q >> 4;
        end
    end

    assign nib = row_q[3:0];

    // Flipped rows run from x+7 down to x
    assign offset = flip_q ? 3'd7 - cnt : cnt;

    // Address wraps modulo 256
    assign wr_addr        = x_q + {5'd0, offset};
    assign wr_pixel.color = color_q;
    assign wr_pixel.idx   = nib;

    // Index 0 is transparent and leaves the buffer alone
    assign wr_en     = busy && (nib != 4'd0);
    assign draw_busy = busy;

endmodule

/* verilog/obj_scan.sv */
// Line scanner, walks the object table after hinit and fetches ROM rows of the objects hit
`timescale 1ns/1ps
`include "obj_defines.svh"

module obj_scan (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   hinit,
    input  logic [7:0]             vrender,
    // Attribute table scan port
    input  logic [7:0]             even_q,
    input  logic [7:0]             odd_q,
    output logic [5:0]             scan_addr,
    // Graphics ROM
    output logic [`OBJ_ROM_AW-1:0] rom_addr,
    output logic                   rom_cs,
    input  logic [31:0]            rom_data,
    input  logic                   rom_ok,
    // Drawer handoff
    input  logic                   draw_busy,
    output logic                   draw_start,
    output logic [31:0]            draw_data,
    output logic [7:0]             draw_x,
    output logic [7:0]             draw_attr
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR0,   // request bytes 0 and 1
        S_ADDR1,   // request bytes 2 and 3, take y and code
        S_TEST,    // take attr and x, hit test
        S_ROM,     // hold the ROM strobe
        S_HAND     // wait for the drawer
    } state_t;

    state_t                 state;
    obj_pkg::obj_index_t    idx;
    obj_pkg::obj_entry_t    entry;
    logic [7:0]             line;
    logic [7:0]             row_diff;
    logic                   hit;
    logic                   last;

    // Entry n sits at scan words 2n and 2n+1
    assign scan_addr = {idx, state == S_ADDR1};

    // Row inside the object, wraps modulo 256
    assign row_diff = line - entry.y;
    assign hit      = row_diff < 8'(obj_pkg::OBJ_ROWS);
    assign last     = idx == obj_pkg::obj_index_t'(`OBJ_COUNT - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            idx        <= '0;
            line       <= '0;
            rom_cs     <= 1'b0;
            draw_start <= 1'b0;
        end else begin
            // One cycle pulse
            draw_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (hinit) begin
                        idx   <= '0;
                        line  <= vrender + 8'd1;
                        state <= S_ADDR0;
                    end
                end
                S_ADDR0: state <= S_ADDR1;
                S_ADDR1: state <= S_TEST;
                S_TEST: begin
                    if (hit) begin
                        rom_cs <= 1'b1;
                        state  <= S_ROM;
                    end else if (last) begin
                        state <= S_IDLE;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= S_ADDR0;
                    end
                end
                S_ROM: begin
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        state  <= S_HAND;
                    end
                end
                S_HAND: begin
                    // Drawer latches its own copy, so the scan goes on at once
                    if (!draw_busy) begin
                        draw_start <= 1'b1;
                        if (last) begin
                            state <= S_IDLE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= S_ADDR0;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Entry bytes, ROM address and handoff payload
    always_ff @(posedge clk) begin
        if (state == S_ADDR1) begin
            entry.y    <= even_q;
            entry.code <= odd_q;
        end
        if (state == S_TEST) begin
            entry.attr <= even_q;
            entry.x    <= odd_q;
            // Held stable with rom_cs until rom_ok
            rom_addr   <= {entry.code, row_diff[2:0]};
        end
        if (state == S_ROM && rom_ok) begin
            draw_data <= rom_data;
            draw_x    <= entry.x;
            draw_attr <= entry.attr;
        end
    end

endmodule

/* verilog/obj_ram.sv */
// Object attribute table, two byte banks with a CPU port and a scan port for the line scanner
`timescale 1ns/1ps
`include "obj_defines.svh"

module obj_ram (
    input  logic       clk,
    input  logic       rst_n,
    // CPU side
    input  logic [6:0] cpu_addr,
    input  logic [7:0] cpu_dout,
    input  logic       obj_cs,
    input  logic       cpu_rnw,
    output logic [7:0] obj_dout,
    // Scanner side
    input  logic [5:0] scan_addr,
    output logic [7:0] even_q,
    output logic [7:0] odd_q
);

    // Even bank holds bytes 0 and 2, odd bank bytes 1 and 3
    logic [7:0] even_mem [`OBJ_COUNT*2];
    logic [7:0] odd_mem  [`OBJ_COUNT*2];

    logic [5:0] bank_addr;
    logic       even_we;
    logic       odd_we;

    // Bit 0 picks the bank, the rest is the word inside it
    assign bank_addr = cpu_addr[6:1];
    assign even_we   = obj_cs & ~cpu_rnw & ~cpu_addr[0];
    assign odd_we    = obj_cs & ~cpu_rnw &  cpu_addr[0];

    // CPU writes
    always_ff @(posedge clk) begin
        if (even_we) begin
            even_mem[bank_addr] <= cpu_dout;
        end
        if (odd_we) begin
            odd_mem[bank_addr] <= cpu_dout;
        end
    end

    // Registered reads, one cycle latency on both ports
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            obj_dout <= '0;
            even_q   <= '0;
            odd_q    <= '0;
        end else begin
            // CPU readback follows its own bank select
            obj_dout <= cpu_addr[0] ? odd_mem[bank_addr] : even_mem[bank_addr];
            // Scanner gets both bytes of a half entry at once
            even_q   <= even_mem[scan_addr];
            odd_q    <= odd_mem[scan_addr];
        end
    end

endmodule

/* verilog/video_pkg.sv */
// Pixel and line buffer types shared by the drawer, the line buffer and the top level
package video_pkg;

    // Object pixel as stored in the line buffer
    // Index 0 means no object at this position
    typedef struct packed {
        logic [3:0] color;
        logic [3:0] idx;
    } pixel_t;

    // Position inside one line buffer
    typedef logic [7:0] lbuf_addr_t;

endpackage

/* verilog/obj_pkg.sv */
// Object table types shared by the attribute RAM, the line scanner and the drawer
package obj_pkg;

    // One attribute table entry, byte 0 in the low bits
    // Bytes 0 and 2 sit in the even bank, bytes 1 and 3 in the odd bank
    typedef struct packed {
        logic [7:0] x;     // byte 3, left pixel
        logic [7:0] attr;  // byte 2, flip and color
        logic [7:0] code;  // byte 1, tile number
        logic [7:0] y;     // byte 0, top line
    } obj_entry_t;

    // Object number inside the table
    typedef logic [4:0] obj_index_t;

    // Attribute byte layout
    // Bit 4 flips the row, bits 3..0 are the color
    localparam int ATTR_FLIP = 4;

    // Object height in lines
    localparam int OBJ_ROWS = 8;

endpackage

/* include/obj_defines.svh */
// Object engine sizing constants, included by the RTL and the testbench
`ifndef OBJ_DEFINES_SVH
`define OBJ_DEFINES_SVH

// Entries in the object attribute table
// Each entry is four bytes, split over the even and odd banks
`define OBJ_COUNT 32

// Graphics ROM word address width
// Tile code times 8 plus the row inside the tile
`define OBJ_ROM_AW 11

// Display read lag in pixels
// The pixel shown at hdump h comes from line buffer position h - OBJ_HOFFSET
`define OBJ_HOFFSET 6

`endif
